/* rtl/any1_settings.svh */
`ifndef ANY1_SETTINGS_SVH
`define ANY1_SETTINGS_SVH

// ==========================================================
// Decoder widths
// ==========================================================

// One instruction word as fetched
`define ANY1_INSTR_W 32

// Fetch address and predicted next address
`define ANY1_ADDR_W 32

// Register number, enough for 64 integer registers
`define ANY1_REG_W 6

// Immediate handed to the 64-bit datapath
`define ANY1_IMM_W 64

// Stream tag carried alongside each instruction
`define ANY1_STREAM_W 3

`endif

/* rtl/any1_pkg.sv */
package any1_pkg;

`include "any1_settings.svh"

	// ==========================================================
	// Width types
	// ==========================================================

	typedef logic [`ANY1_REG_W-1:0] reg_t;
	typedef logic [`ANY1_ADDR_W-1:0] addr_t;
	typedef logic [`ANY1_IMM_W-1:0] imm_t;
	typedef logic [`ANY1_STREAM_W-1:0] stream_t;

	// ==========================================================
	// Opcode and function encodings
	// ==========================================================

	// Opcodes with bit 7 set belong to the vector and float space
	typedef enum logic [7:0] {
		BRK    = 8'h00, NOP    = 8'h01,
		R1     = 8'h02, R2     = 8'h03, R3     = 8'h04,
		ADDI   = 8'h08, SUBFI  = 8'h09, ANDI   = 8'h0A, ORI    = 8'h0B,
		XORI   = 8'h0C, SLTI   = 8'h0D, SLTUI  = 8'h0E, BYTNDX = 8'h0F,
		CHKI   = 8'h10,
		JAL    = 8'h40, BAL    = 8'h41, JALR   = 8'h42,
		BEQ    = 8'h48, BNE    = 8'h49, BLT    = 8'h4A, BGE    = 8'h4B,
		BLTU   = 8'h4C, BGEU   = 8'h4D, BBS    = 8'h4E,
		EXI0   = 8'h50, EXI1   = 8'h51, EXI2   = 8'h52, IMOD   = 8'h53,
		BRMOD  = 8'h54, STRIDE = 8'h55,
		LDX    = 8'h60, LEA    = 8'h61, LDXX   = 8'h62,
		STX    = 8'h68, STXX   = 8'h69,
		CSR    = 8'h70, SYS    = 8'h71
	} opcode_e;

	// Function field of the R1, R2, R3 and SYS groups
	typedef enum logic [5:0] {
		ABS    = 6'h00, NOT    = 6'h01,
		ADD    = 6'h04, SUB    = 6'h05,
		AND    = 6'h08, OR     = 6'h09, XOR    = 6'h0A,
		SLT    = 6'h0C, SLTU   = 6'h0D,
		MUL    = 6'h10, DIV    = 6'h14,
		SLL    = 6'h20, PTRDIF = 6'h21, CHK    = 6'h22,
		PFI    = 6'h30, TLBRW  = 6'h31
	} func_e;

	// ==========================================================
	// Instruction word views
	// ==========================================================

	typedef struct packed {
		func_e func;
		logic [5:0] rb;
		logic [5:0] ra;
		logic [5:0] rt;
		opcode_e opcode;
	} r2_fmt_t;

	typedef struct packed {
		logic [3:0] pad;
		logic [7:0] disp;
		logic [5:0] ra;
		logic [5:0] rt;
		opcode_e opcode;
	} ld_fmt_t;

	// Stores put the data register where the others put Rt
	typedef struct packed {
		logic [3:0] pad;
		logic [1:0] disphi;
		logic [5:0] displo;
		logic [5:0] ra;
		logic [5:0] rs;
		opcode_e opcode;
	} st_fmt_t;

	typedef union packed {
		r2_fmt_t r2;
		ld_fmt_t ld;
		st_fmt_t st;
	} instr_t;

	// ==========================================================
	// Decode control kinds
	// ==========================================================

	typedef enum logic [3:0] {
		IMM_NONE, IMM_SEXT12, IMM_ONES12, IMM_ZEXT12, IMM_ZEXT8,
		IMM_JAL, IMM_JALR, IMM_BRANCH, IMM_LDDISP, IMM_STDISP
	} imm_kind_e;

	typedef enum logic [1:0] {
		DEST_NONE, DEST_FIELD, DEST_LINK
	} dest_kind_e;

endpackage

/* rtl/any1_dec_ctrl_if.sv */
`timescale 1ns/1ps

interface any1_dec_ctrl_if;
	import any1_pkg::*;

	// Flags that go straight into the decode record
	logic ui;
	logic rfwr;
	logic need_rc;
	logic branch;
	logic is_mod;
	logic stream_inc;

	// Steering for the register and immediate builders
	dest_kind_e dest_kind;
	imm_kind_e imm_kind;
	// Rc comes from bits 13:8 when set
	logic rc_sel;

	modport src (
		output ui, rfwr, need_rc, branch, is_mod, stream_inc,
		output dest_kind, imm_kind, rc_sel
	);

	modport dst (
		input ui, rfwr, need_rc, branch, is_mod, stream_inc,
		input dest_kind, imm_kind, rc_sel
	);

endinterface

/* rtl/any1_opclass.sv */
`timescale 1ns/1ps

module any1_opclass (
	input any1_pkg::instr_t instr,
	any1_dec_ctrl_if.src ctrl
);
	import any1_pkg::*;

	// Set by every form that writes the Rt field of the word
	logic wr_field;

	always_comb begin
		wr_field = 1'b0;
		ctrl.ui = 1'b1;
		ctrl.rfwr = 1'b0;
		ctrl.need_rc = 1'b0;
		ctrl.rc_sel = 1'b0;
		ctrl.stream_inc = 1'b0;
		ctrl.dest_kind = DEST_NONE;
		ctrl.imm_kind = IMM_NONE;
		// The whole 48..4F block is flagged as a branch, known or not
		ctrl.branch = (instr.r2.opcode[7:3] == 5'b01001);
		ctrl.is_mod = (instr.r2.opcode[7:4] == 4'h5);

		case (instr.r2.opcode)
			BRK, NOP: ctrl.ui = 1'b0;

			// ==========================================================
			// Register forms
			// ==========================================================
			R1:
				case (instr.r2.func)
					ABS, NOT: begin
						ctrl.ui = 1'b0;
						wr_field = 1'b1;
					end
					default: ;
				endcase
			R2:
				case (instr.r2.func)
					ADD, SUB, AND, OR, XOR, SLT, SLTU, MUL, DIV: begin
						ctrl.ui = 1'b0;
						wr_field = 1'b1;
					end
					default: ;
				endcase
			R3:
				case (instr.r2.func)
					SLL, PTRDIF: begin
						ctrl.ui = 1'b0;
						wr_field = 1'b1;
					end
					// Bounds check reads a third register and writes nothing
					CHK: begin
						ctrl.ui = 1'b0;
						ctrl.need_rc = 1'b1;
						ctrl.rc_sel = 1'b1;
					end
					default: ;
				endcase

			// ==========================================================
			// Immediate ALU forms
			// ==========================================================
			ADDI, SUBFI, SLTI: begin
				ctrl.ui = 1'b0;
				wr_field = 1'b1;
				ctrl.imm_kind = IMM_SEXT12;
			end
			ANDI: begin
				ctrl.ui = 1'b0;
				wr_field = 1'b1;
				ctrl.imm_kind = IMM_ONES12;
			end
			ORI, XORI, SLTUI: begin
				ctrl.ui = 1'b0;
				wr_field = 1'b1;
				ctrl.imm_kind = IMM_ZEXT12;
			end
			BYTNDX: begin
				ctrl.ui = 1'b0;
				wr_field = 1'b1;
				ctrl.imm_kind = IMM_ZEXT8;
			end
			CHKI: begin
				ctrl.ui = 1'b0;
				ctrl.imm_kind = IMM_SEXT12;
			end

			// ==========================================================
			// Control transfer
			// ==========================================================
			JAL, BAL: begin
				ctrl.ui = 1'b0;
				ctrl.rfwr = 1'b1;
				ctrl.dest_kind = DEST_LINK;
				ctrl.imm_kind = IMM_JAL;
				ctrl.stream_inc = 1'b1;
			end
			JALR: begin
				ctrl.ui = 1'b0;
				ctrl.rfwr = 1'b1;
				ctrl.dest_kind = DEST_LINK;
				ctrl.imm_kind = IMM_JALR;
			end
			BEQ, BNE, BLT, BGE, BLTU, BGEU, BBS: begin
				ctrl.ui = 1'b0;
				ctrl.imm_kind = IMM_BRANCH;
			end
			EXI0, EXI1, EXI2, IMOD, BRMOD, STRIDE: ctrl.ui = 1'b0;

			// ==========================================================
			// Memory and system
			// ==========================================================
			LEA, LDX: begin
				ctrl.ui = 1'b0;
				wr_field = 1'b1;
				ctrl.imm_kind = IMM_LDDISP;
			end
			LDXX: begin
				ctrl.ui = 1'b0;
				wr_field = 1'b1;
			end
			// Store data rides in the Rt slot and is read as Rc
			STX: begin
				ctrl.ui = 1'b0;
				ctrl.rfwr = 1'b1;
				ctrl.need_rc = 1'b1;
				ctrl.rc_sel = 1'b1;
				ctrl.imm_kind = IMM_STDISP;
			end
			STXX: ctrl.ui = 1'b0;
			CSR: begin
				ctrl.ui = 1'b0;
				ctrl.dest_kind = DEST_FIELD;
				ctrl.imm_kind = IMM_ZEXT12;
			end
			SYS:
				case (instr.r2.func)
					PFI: ctrl.ui = 1'b0;
					TLBRW: begin
						ctrl.ui = 1'b0;
						wr_field = 1'b1;
					end
					default: ;
				endcase
			default: ;
		endcase

		if (wr_field) begin
			ctrl.rfwr = 1'b1;
			ctrl.dest_kind = DEST_FIELD;
		end
	end

endmodule

/* rtl/any1_imm_gen.sv */
`timescale 1ns/1ps

`include "any1_settings.svh"

module any1_imm_gen (
	input any1_pkg::instr_t instr,
	any1_dec_ctrl_if.dst ctrl,
	output any1_pkg::imm_t imm
);
	import any1_pkg::*;

	// The 12-bit field shared by the ALU immediates, JALR and CSR
	logic [11:0] imm12;

	assign imm12 = instr[31:20];

	always_comb begin
		case (ctrl.imm_kind)
			IMM_SEXT12:
				imm = {{(`ANY1_IMM_W-12){imm12[11]}}, imm12};
			// ANDI keeps the upper bits of the source untouched
			IMM_ONES12:
				imm = {{(`ANY1_IMM_W-12){1'b1}}, imm12};
			IMM_ZEXT12:
				imm = {{(`ANY1_IMM_W-12){1'b0}}, imm12};
			IMM_ZEXT8:
				imm = {{(`ANY1_IMM_W-8){1'b0}}, instr.ld.disp};

			// ==========================================================
			// Word-aligned control transfer offsets
			// ==========================================================
			IMM_JAL:
				imm = {{(`ANY1_IMM_W-24){instr[31]}}, instr[31:10], 2'b00};
			IMM_JALR:
				imm = {{(`ANY1_IMM_W-14){imm12[11]}}, imm12, 2'b00};
			// Branch offset is split around the Ra and Rb fields
			IMM_BRANCH:
				imm = {{(`ANY1_IMM_W-14){instr[31]}}, instr[31:26], instr[13:8], 2'b00};

			// ==========================================================
			// Memory displacements
			// ==========================================================
			IMM_LDDISP:
				imm = {{(`ANY1_IMM_W-8){instr.ld.disp[7]}}, instr.ld.disp};
			IMM_STDISP:
				imm = {{(`ANY1_IMM_W-8){instr.st.disphi[1]}}, instr.st.disphi,
					instr.st.displo};
			default:
				imm = '0;
		endcase
	end

endmodule

/* rtl/any1_regsel.sv */
`timescale 1ns/1ps

module any1_regsel (
	input any1_pkg::instr_t instr,
	any1_dec_ctrl_if.dst ctrl,
	output any1_pkg::reg_t ra,
	output any1_pkg::reg_t rb,
	output any1_pkg::reg_t rc,
	output any1_pkg::reg_t rt
);
	import any1_pkg::*;

	// Source fields sit in the same place for every format
	assign ra = instr.r2.ra;
	assign rb = instr.r2.rb;

	// Store data and the CHK bound share the slot at bits 13:8
	assign rc = ctrl.rc_sel ? instr.st.rs : '0;

	always_comb begin
		case (ctrl.dest_kind)
			DEST_FIELD:
				rt = instr.r2.rt;
			// Only four link registers, picked by the low two bits
			DEST_LINK:
				rt = reg_t'(instr[9:8]);
			default:
				rt = '0;
		endcase
	end

endmodule

/* rtl/any1_decode_reg.sv */
`timescale 1ns/1ps

module any1_decode_reg (
	input logic clk,
	input logic arst_n,
	input logic instr_valid,
	any1_dec_ctrl_if.dst ctrl,
	input any1_pkg::reg_t ra,
	input any1_pkg::reg_t rb,
	input any1_pkg::reg_t rc,
	input any1_pkg::reg_t rt,
	input any1_pkg::imm_t imm,
	input any1_pkg::addr_t ip,
	input any1_pkg::addr_t predicted_ip,
	input logic predict_taken,
	input any1_pkg::stream_t stream,
	output logic dec_valid,
	output logic dec_ui,
	output logic dec_rfwr,
	output logic dec_need_rc,
	output logic dec_branch,
	output logic dec_is_mod,
	output logic dec_stream_inc,
	output any1_pkg::reg_t dec_ra,
	output any1_pkg::reg_t dec_rb,
	output any1_pkg::reg_t dec_rc,
	output any1_pkg::reg_t dec_rt,
	output any1_pkg::imm_t dec_imm,
	output any1_pkg::addr_t dec_ip,
	output any1_pkg::addr_t dec_pip,
	output logic dec_predict_taken,
	output any1_pkg::stream_t dec_stream
);

	// The record is held until the next valid word replaces it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
			dec_ui <= 1'b0;
			dec_rfwr <= 1'b0;
			dec_need_rc <= 1'b0;
			dec_branch <= 1'b0;
			dec_is_mod <= 1'b0;
			dec_stream_inc <= 1'b0;
			dec_ra <= '0;
			dec_rb <= '0;
			dec_rc <= '0;
			dec_rt <= '0;
			dec_imm <= '0;
			dec_ip <= '0;
			dec_pip <= '0;
			dec_predict_taken <= 1'b0;
			dec_stream <= '0;
		end else begin
			dec_valid <= instr_valid;
			if (instr_valid) begin
				dec_ui <= ctrl.ui;
				dec_rfwr <= ctrl.rfwr;
				dec_need_rc <= ctrl.need_rc;
				dec_branch <= ctrl.branch;
				dec_is_mod <= ctrl.is_mod;
				dec_stream_inc <= ctrl.stream_inc;
				dec_ra <= ra;
				dec_rb <= rb;
				dec_rc <= rc;
				dec_rt <= rt;
				dec_imm <= imm;
				dec_ip <= ip;
				dec_pip <= predicted_ip;
				dec_predict_taken <= predict_taken;
				dec_stream <= stream;
			end
		end
	end

endmodule

/* rtl/any1_decode_top.sv */
`timescale 1ns/1ps

`include "any1_settings.svh"

module any1_decode_top (
	input logic clk,
	input logic arst_n,
	input logic instr_valid,
	input logic [`ANY1_INSTR_W-1:0] instr,
	input logic [`ANY1_ADDR_W-1:0] ip,
	input logic [`ANY1_ADDR_W-1:0] predicted_ip,
	input logic predict_taken,
	input logic [`ANY1_STREAM_W-1:0] stream,
	output logic dec_valid,
	output logic dec_ui,
	output logic dec_rfwr,
	output logic dec_need_rc,
	output logic dec_branch,
	output logic dec_is_mod,
	output logic dec_stream_inc,
	output logic [`ANY1_REG_W-1:0] dec_ra,
	output logic [`ANY1_REG_W-1:0] dec_rb,
	output logic [`ANY1_REG_W-1:0] dec_rc,
	output logic [`ANY1_REG_W-1:0] dec_rt,
	output logic [`ANY1_IMM_W-1:0] dec_imm,
	output logic [`ANY1_ADDR_W-1:0] dec_ip,
	output logic [`ANY1_ADDR_W-1:0] dec_pip,
	output logic dec_predict_taken,
	output logic [`ANY1_STREAM_W-1:0] dec_stream
);

	// ==========================================================
	// Combinational decode
	// ==========================================================

	logic [`ANY1_REG_W-1:0] ra;
	logic [`ANY1_REG_W-1:0] rb;
	logic [`ANY1_REG_W-1:0] rc;
	logic [`ANY1_REG_W-1:0] rt;
	logic [`ANY1_IMM_W-1:0] imm;

	any1_dec_ctrl_if ctrl ();

	any1_opclass u_opclass (
		.instr (instr),
		.ctrl  (ctrl)
	);

	any1_imm_gen u_imm_gen (
		.instr (instr),
		.ctrl  (ctrl),
		.imm   (imm)
	);

	any1_regsel u_regsel (
		.instr (instr),
		.ctrl  (ctrl),
		.ra    (ra),
		.rb    (rb),
		.rc    (rc),
		.rt    (rt)
	);

	// ==========================================================
	// Stage register
	// ==========================================================

	any1_decode_reg u_decode_reg (
		.clk               (clk),
		.arst_n            (arst_n),
		.instr_valid       (instr_valid),
		.ctrl              (ctrl),
		.ra                (ra),
		.rb                (rb),
		.rc                (rc),
		.rt                (rt),
		.imm               (imm),
		.ip                (ip),
		.predicted_ip      (predicted_ip),
		.predict_taken     (predict_taken),
		.stream            (stream),
		.dec_valid         (dec_valid),
		.dec_ui            (dec_ui),
		.dec_rfwr          (dec_rfwr),
		.dec_need_rc       (dec_need_rc),
		.dec_branch        (dec_branch),
		.dec_is_mod        (dec_is_mod),
		.dec_stream_inc    (dec_stream_inc),
		.dec_ra            (dec_ra),
		.dec_rb            (dec_rb),
		.dec_rc            (dec_rc),
		.dec_rt            (dec_rt),
		.dec_imm           (dec_imm),
		.dec_ip            (dec_ip),
		.dec_pip           (dec_pip),
		.dec_predict_taken (dec_predict_taken),
		.dec_stream        (dec_stream)
	);

endmodule

/* verification/tb_any1_decode.sv */
`timescale 1ns/1ps

`include "any1_settings.svh"

module tb_any1_decode;

	localparam int TIMEOUT_CYCLES = 20;
	localparam string STIM_FILE = "verification/any1_decode_stim.txt";

	// ==========================================================
	// DUT signals
	// ==========================================================

	logic clk;
	logic arst_n;
	logic instr_valid;
	logic [`ANY1_INSTR_W-1:0] instr;
	logic [`ANY1_ADDR_W-1:0] ip;
	logic [`ANY1_ADDR_W-1:0] predicted_ip;
	logic predict_taken;
	logic [`ANY1_STREAM_W-1:0] stream;
	logic dec_valid;
	logic dec_ui;
	logic dec_rfwr;
	logic dec_need_rc;
	logic dec_branch;
	logic dec_is_mod;
	logic dec_stream_inc;
	logic [`ANY1_REG_W-1:0] dec_ra;
	logic [`ANY1_REG_W-1:0] dec_rb;
	logic [`ANY1_REG_W-1:0] dec_rc;
	logic [`ANY1_REG_W-1:0] dec_rt;
	logic [`ANY1_IMM_W-1:0] dec_imm;
	logic [`ANY1_ADDR_W-1:0] dec_ip;
	logic [`ANY1_ADDR_W-1:0] dec_pip;
	logic dec_predict_taken;
	logic [`ANY1_STREAM_W-1:0] dec_stream;

	// One vector from the stimulus file, inputs first
	string label;
	logic [`ANY1_INSTR_W-1:0] v_instr;
	logic [`ANY1_ADDR_W-1:0] v_ip;
	logic [`ANY1_ADDR_W-1:0] v_pip;
	logic v_pt;
	logic [`ANY1_STREAM_W-1:0] v_stream;
	logic e_ui, e_rfwr, e_need_rc, e_branch, e_is_mod, e_stream_inc;
	logic [`ANY1_REG_W-1:0] e_ra, e_rb, e_rc, e_rt;
	logic [`ANY1_IMM_W-1:0] e_imm;

	int errors;
	int tests_run;
	int tests_failed;

	any1_decode_top UUT (
		.clk               (clk),
		.arst_n            (arst_n),
		.instr_valid       (instr_valid),
		.instr             (instr),
		.ip                (ip),
		.predicted_ip      (predicted_ip),
		.predict_taken     (predict_taken),
		.stream            (stream),
		.dec_valid         (dec_valid),
		.dec_ui            (dec_ui),
		.dec_rfwr          (dec_rfwr),
		.dec_need_rc       (dec_need_rc),
		.dec_branch        (dec_branch),
		.dec_is_mod        (dec_is_mod),
		.dec_stream_inc    (dec_stream_inc),
		.dec_ra            (dec_ra),
		.dec_rb            (dec_rb),
		.dec_rc            (dec_rc),
		.dec_rt            (dec_rt),
		.dec_imm           (dec_imm),
		.dec_ip            (dec_ip),
		.dec_pip           (dec_pip),
		.dec_predict_taken (dec_predict_taken),
		.dec_stream        (dec_stream)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==========================================================
	// Helpers
	// ==========================================================

	task automatic check_field(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t ns: %s %s is %h, expected %h", $time, label, what, got, exp);
			errors++;
		end
	endtask

	task automatic drive_vector();
		instr_valid = 1'b1;
		instr = v_instr;
		ip = v_ip;
		predicted_ip = v_pip;
		predict_taken = v_pt;
		stream = v_stream;
	endtask

	// Valid is only offered for the first edge after the drive
	task automatic wait_for_record(output int cycles);
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			instr_valid = 1'b0;
			cycles++;
		end while (!dec_valid && cycles < TIMEOUT_CYCLES);
	endtask

	task automatic check_record(input int cycles);
		check_field("latency", cycles, 1);
		check_field("dec_ui", dec_ui, e_ui);
		check_field("dec_rfwr", dec_rfwr, e_rfwr);
		check_field("dec_need_rc", dec_need_rc, e_need_rc);
		check_field("dec_branch", dec_branch, e_branch);
		check_field("dec_is_mod", dec_is_mod, e_is_mod);
		check_field("dec_stream_inc", dec_stream_inc, e_stream_inc);
		check_field("dec_ra", dec_ra, e_ra);
		check_field("dec_rb", dec_rb, e_rb);
		check_field("dec_rc", dec_rc, e_rc);
		check_field("dec_rt", dec_rt, e_rt);
		check_field("dec_imm", dec_imm, e_imm);
		// Pass-through fields come back exactly as driven
		check_field("dec_ip", dec_ip, v_ip);
		check_field("dec_pip", dec_pip, v_pip);
		check_field("dec_predict_taken", dec_predict_taken, v_pt);
		check_field("dec_stream", dec_stream, v_stream);
	endtask

	task automatic idle_cycles(input int gap);
		repeat (gap) begin
			@(posedge clk);
			#1;
			check_field("dec_valid in idle", dec_valid, 0);
			check_field("held dec_imm", dec_imm, e_imm);
			check_field("held dec_ip", dec_ip, v_ip);
		end
	endtask

	task automatic report_test(input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %0d %s: ok", tests_run, label);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d mismatches", tests_run, label, errors - errs_before);
		end
	endtask

	task automatic check_reset_state();
		int errs_before;
		errs_before = errors;
		label = "reset";
		check_field("dec_valid", dec_valid, 0);
		check_field("flags", {dec_ui, dec_rfwr, dec_need_rc, dec_branch, dec_is_mod,
			dec_stream_inc, dec_predict_taken}, 0);
		check_field("registers", {dec_ra, dec_rb, dec_rc, dec_rt}, 0);
		check_field("dec_imm", dec_imm, 0);
		check_field("dec_ip", dec_ip, 0);
		check_field("dec_pip", dec_pip, 0);
		check_field("dec_stream", dec_stream, 0);
		report_test(errs_before);
	endtask

	// ==========================================================
	// Vector loop
	// ==========================================================

	task automatic apply_vectors(input int fd);
		string line;
		int n;
		int cycles;
		int gap;
		int errs_before;
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				label, v_instr, v_ip, v_pip, v_pt, v_stream, e_ui, e_rfwr, e_need_rc,
				e_branch, e_is_mod, e_stream_inc, e_ra, e_rb, e_rc, e_rt, e_imm);
			if (n <= 0 || line[0] == "#") begin
				continue;
			end
			if (n != 17) begin
				$display("Stimulus line could not be read: %s", line);
				errors++;
				continue;
			end
			errs_before = errors;
			drive_vector();
			wait_for_record(cycles);
			if (!dec_valid) begin
				$display("Timed out waiting for dec_valid on test %s", label);
				errors++;
				report_test(errs_before);
				break;
			end else begin
				check_record(cycles);
				// A gap of zero sends the next word back to back
				gap = $urandom % 4;
				idle_cycles(gap);
				report_test(errs_before);
			end
		end
	endtask

	initial begin
		int fd;
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		ip = '0;
		predicted_ip = '0;
		predict_taken = 1'b0;
		stream = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'h1cbd_80a4));

		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check_reset_state();

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %s", STIM_FILE);
			$display("Simulation FAILED");
			$finish;
		end else begin
			apply_vectors(fd);
			$fclose(fd);
			$display("Tests run: %0d, tests failed: %0d, mismatches: %0d",
				tests_run, tests_failed, errors);
			if (errors == 0) begin
				$display("Simulation PASSED");
			end else begin
				$display("Simulation FAILED");
			end
			$finish;
		end
	end

endmodule

/* verification/any1_decode_stim.txt */
# label instr ip pip pt stream | ui rfwr need_rc branch is_mod stream_inc ra rb rc rt imm
# All values in hex; ip, pip, pt and stream are expected back unchanged
r2_add   10308103 00001000 00001004 0 0  0 1 0 0 0 0 02 03 00 01 0000000000000000
r1_not   04014702 00001004 00001008 1 1  0 1 0 0 0 0 05 00 00 07 0000000000000000
r3_sll   83F42A04 00001008 0000100C 0 2  0 1 0 0 0 0 10 3F 00 2A 0000000000000000
r3_chk   88418904 0000100C 00001010 1 3  0 0 1 0 0 0 06 04 09 00 0000000000000000
r2_mul   40104203 00001010 00001014 0 4  0 1 0 0 0 0 01 01 00 02 0000000000000000
addi_neg FFE0C408 00001014 00001018 1 5  0 1 0 0 0 0 03 3E 00 04 FFFFFFFFFFFFFFFE
addi_pos 12304208 00001018 0000101C 0 6  0 1 0 0 0 0 01 23 00 02 0000000000000123
subfi    80000109 0000101C 00001020 1 7  0 1 0 0 0 0 00 00 00 01 FFFFFFFFFFFFF800
andi     0F00820A 00001020 00001024 0 0  0 1 0 0 0 0 02 30 00 02 FFFFFFFFFFFFF0F0
ori      ABC1C80B 00001024 00001028 1 1  0 1 0 0 0 0 07 3C 00 08 0000000000000ABC
xori     FFF0010C 00001028 0000102C 0 2  0 1 0 0 0 0 00 3F 00 01 0000000000000FFF
slti     7FF0430D 0000102C 00001030 1 3  0 1 0 0 0 0 01 3F 00 03 00000000000007FF
sltui    8010000E 00001030 00001034 0 4  0 1 0 0 0 0 00 01 00 00 0000000000000801
bytndx   F850830F 00001034 00001038 1 5  0 1 0 0 0 0 02 05 00 03 0000000000000085
chki     F0010510 00001038 0000103C 0 6  0 0 0 0 0 0 04 00 00 00 FFFFFFFFFFFFFF00
jal      00001240 0000103C 00001050 1 7  0 1 0 0 0 1 00 00 00 02 0000000000000010
bal_neg  FFFFFD41 00001050 0000104C 1 0  0 1 0 0 0 1 3F 3F 00 01 FFFFFFFFFFFFFFFC
jalr_neg FF814342 80000000 7FFFFFE0 0 1  0 1 0 0 0 0 05 38 00 03 FFFFFFFFFFFFFFE0
jalr_pos 01003D42 FFFFFFFC 0000003C 1 2  0 1 0 0 0 0 00 10 00 01 0000000000000040
beq      FC207E48 00002000 00001FF8 1 3  0 0 0 1 0 0 01 02 00 00 FFFFFFFFFFFFFFF8
bltu     03FFFF4C 00002004 00002008 0 4  0 0 0 1 0 0 3F 3F 00 00 00000000000000FC
bbs      0440C54E 00002008 0000211C 1 5  0 0 0 1 0 0 03 04 00 00 0000000000000114
imod     12345653 0000200C 00002010 0 6  0 0 0 0 1 0 11 23 00 00 0000000000000000
stride   00000055 00002010 00002014 0 7  0 0 0 0 1 0 00 00 00 00 0000000000000000
exi0     00000050 00002014 00002018 1 0  0 0 0 0 1 0 00 00 00 00 0000000000000000
lea      08008361 00002018 0000201C 0 1  0 1 0 0 0 0 02 00 00 03 FFFFFFFFFFFFFF80
ldx      A7FFE160 0000201C 00002020 1 2  0 1 0 0 0 0 3F 3F 00 21 000000000000007F
ldxx     00123462 00002020 00002024 0 3  0 1 0 0 0 0 08 01 00 34 0000000000000000
stx      0C529168 00002024 00002028 1 4  0 1 1 0 0 0 0A 05 11 00 FFFFFFFFFFFFFFC5
stxx     00004069 00002028 0000202C 0 5  0 0 0 0 0 0 01 00 00 00 0000000000000000
csr      C0100F70 0000202C 00002030 1 6  0 0 0 0 0 0 00 01 00 0F 0000000000000C01
tlbrw    C4004271 00002030 00002034 0 7  0 1 0 0 0 0 01 00 00 02 0000000000000000
pfi      C0000071 00002034 00002038 1 0  0 0 0 0 0 0 00 00 00 00 0000000000000000
brk      00000000 00002038 0000203C 0 1  0 0 0 0 0 0 00 00 00 00 0000000000000000
nop      00000001 0000203C 00002040 1 2  0 0 0 0 0 0 00 00 00 00 0000000000000000
bad_func 08000003 00002040 00002044 0 3  1 0 0 0 0 0 00 00 00 00 0000000000000000
bad_sys  FC000071 00002044 00002048 1 4  1 0 0 0 0 0 00 00 00 00 0000000000000000
op_4f    0000004F 00002048 0000204C 0 5  1 0 0 1 0 0 00 00 00 00 0000000000000000
op_56    00000056 0000204C 00002050 1 6  1 0 0 0 1 0 00 00 00 00 0000000000000000
op_80    00000080 00002050 00002054 0 7  1 0 0 0 0 0 00 00 00 00 0000000000000000
op_c8    123456C8 00002054 00002058 1 0  1 0 0 0 0 0 11 23 00 00 0000000000000000
op_ff    FFFFFFFF 00002058 0000205C 0 1  1 0 0 0 0 0 3F 3F 00 00 0000000000000000

/* filelist.f */
+incdir+rtl
rtl/any1_pkg.sv
rtl/any1_dec_ctrl_if.sv
rtl/any1_opclass.sv
rtl/any1_imm_gen.sv
rtl/any1_regsel.sv
rtl/any1_decode_reg.sv
rtl/any1_decode_top.sv
verification/tb_any1_decode.sv
